// File: project.f
+incdir+design
design/cpu_pkg.sv
design/memctrl.sv
design/fetcher.sv
design/decoder.sv
design/regfile.sv
design/execute.sv
design/cpu.sv
dv/tb_mem_model.sv
dv/tb_cpu.sv

// File: Makefile
# Verilator build and run of the RV32I core testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f project.f --top-module tb_cpu -Mdir obj_dir -o sim_cpu
	./obj_dir/sim_cpu | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/tb_cpu.sv
// runs the preloaded sum program on the core with random rdy_in and io_buffer_full
// checks are concurrent assertions on the top-level bus, sampled on the rising edge
`default_nettype none
`include "cpu_config.svh"

module tb_cpu;
    timeunit 1ns;
    timeprecision 100ps;

    // program takes well under 5000 stalled cycles
    localparam int          CYCLE_LIMIT = 20000;
    localparam int          SUM_TERMS   = 10;
    localparam logic [31:0] STORE_ADDR  = 32'h0000_0100;
    localparam logic [31:0] SEED        = 32'hfccddc21;

    logic        clk;
    logic        rst;
    logic        rdy_in;
    logic        io_buffer_full;
    logic [7:0]  mem_din;
    logic [7:0]  mem_dout;
    logic [31:0] mem_a;
    logic        mem_wr;
    logic [31:0] dbgreg_dout;
    logic [7:0]  char_count;
    logic        stop_seen;
    logic        accepted_wr;

    // bus state one edge back
    logic        rst_d;
    logic        rdy_d;
    logic        full_d;
    logic [31:0] a_d;
    logic        wr_d;
    logic [7:0]  dout_d;
    logic [31:0] last_wr_addr;
    int          store_bytes;
    int          cycles;
    int          value_errors = 0;
    int          other_errors = 0;

    cpu UUT (
        .clk_in(clk),
        .rst(rst),
        .rdy_in(rdy_in),
        .mem_din(mem_din),
        .mem_dout(mem_dout),
        .mem_a(mem_a),
        .mem_wr(mem_wr),
        .io_buffer_full(io_buffer_full),
        .dbgreg_dout(dbgreg_dout)
    );

    tb_mem_model mem_model (
        .clk(clk),
        .rst(rst),
        .rdy(rdy_in),
        .addr(mem_a),
        .wr(mem_wr),
        .wdata(mem_dout),
        .rdata(mem_din),
        .char_count(char_count),
        .stop_seen(stop_seen)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // a byte write only lands on an edge where the core advances
    assign accepted_wr = mem_wr && rdy_in;

    function automatic logic [31:0] series_sum(input int n);
        logic [31:0] sum;
        sum = 32'd0;
        for (int i = 1; i <= n; i++)
            sum = sum + 32'(i);
        return sum;
    endfunction

    // STORE_ADDR is word aligned, so the low bits pick the byte
    function automatic logic [7:0] store_byte(input logic [31:0] addr);
        logic [31:0] shifted;
        shifted = series_sum(SUM_TERMS) >> {addr[1:0], 3'b000};
        return shifted[7:0];
    endfunction

    function automatic logic in_store_word(input logic [31:0] addr);
        return addr >= STORE_ADDR && addr <= STORE_ADDR + 32'd3;
    endfunction

    function automatic logic [7:0] expected_char(input logic [7:0] idx);
        logic [31:0] sum;
        sum = series_sum(SUM_TERMS);
        case (idx)
            8'd0:    return 8'h4f;
            8'd1:    return 8'h4b;
            8'd2:    return sum[7:0];
            default: return 8'h00;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        value_errors++;
        $display("[ERROR] t=%0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
    endtask

    always @(posedge clk) begin
        rst_d  <= rst;
        rdy_d  <= rdy_in;
        full_d <= io_buffer_full;
        a_d    <= mem_a;
        wr_d   <= mem_wr;
        dout_d <= mem_dout;
        if (rst) begin
            cycles      <= 0;
            store_bytes <= 0;
        end else begin
            cycles <= cycles + 1;
            if (accepted_wr) begin
                last_wr_addr <= mem_a;
                if (in_store_word(mem_a))
                    store_bytes <= store_bytes + 1;
            end
        end
    end

    reset_no_write: assert property (@(posedge clk) (rst || rst_d) |-> !mem_wr)
        else report_mismatch("mem_wr", 32'd0, 32'($sampled(mem_wr)));
    // first fetch is accepted on the first edge after reset, its address follows
    reset_first_addr: assert property (@(posedge clk) (!rst && rst_d) |=> mem_a == `RESET_PC)
        else report_mismatch("mem_a", `RESET_PC, $sampled(mem_a));

    // stalled edge leaves the bus as it was
    freeze_addr: assert property (@(posedge clk) disable iff (rst)
        (!rdy_d && !rst_d) |-> mem_a == a_d)
        else report_mismatch("mem_a", $sampled(a_d), $sampled(mem_a));
    freeze_dout: assert property (@(posedge clk) disable iff (rst)
        (!rdy_d && !rst_d) |-> mem_dout == dout_d)
        else report_mismatch("mem_dout", 32'($sampled(dout_d)), 32'($sampled(mem_dout)));
    // mem_wr to the output port follows io_buffer_full even while stalled
    freeze_wr: assert property (@(posedge clk) disable iff (rst)
        (!rdy_d && !rst_d && (mem_a != `IO_OUT_ADDR || io_buffer_full == full_d))
        |-> mem_wr == wr_d)
        else report_mismatch("mem_wr", 32'($sampled(wr_d)), 32'($sampled(mem_wr)));

    out_backpressure: assert property (@(posedge clk) disable iff (rst)
        !(mem_wr && io_buffer_full && mem_a == `IO_OUT_ADDR))
        else report_mismatch("mem_wr", 32'd0, 32'($sampled(mem_wr)));

    store_value: assert property (@(posedge clk) disable iff (rst)
        (accepted_wr && in_store_word(mem_a)) |-> mem_dout == store_byte(mem_a))
        else report_mismatch("mem_dout", 32'(store_byte($sampled(mem_a))),
                             32'($sampled(mem_dout)));
    store_consecutive: assert property (@(posedge clk) disable iff (rst)
        (accepted_wr && in_store_word(mem_a) && mem_a != STORE_ADDR)
        |-> mem_a == last_wr_addr + 32'd1)
        else report_mismatch("mem_a", $sampled(last_wr_addr) + 32'd1, $sampled(mem_a));

    out_char: assert property (@(posedge clk) disable iff (rst)
        (accepted_wr && mem_a == `IO_OUT_ADDR) |-> mem_dout == expected_char(char_count))
        else report_mismatch("mem_dout", 32'(expected_char($sampled(char_count))),
                             32'($sampled(mem_dout)));

    stop_dbg: assert property (@(posedge clk) disable iff (rst)
        (accepted_wr && mem_a == `IO_STOP_ADDR) |-> dbgreg_dout == series_sum(SUM_TERMS))
        else report_mismatch("dbgreg_dout", series_sum(SUM_TERMS), $sampled(dbgreg_dout));

    initial begin
        void'($urandom(SEED));
        rst            = 1'b1;
        rdy_in         = 1'b1;
        io_buffer_full = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // stalls about 1 edge in 8, full UART about 1 cycle in 4
        while (!stop_seen && cycles < CYCLE_LIMIT) begin
            @(negedge clk);
            rdy_in         = ($urandom % 8) != 0;
            io_buffer_full = ($urandom % 4) == 0;
        end
        repeat (2) @(negedge clk);

        if (!stop_seen) begin
            other_errors++;
            $display("program never wrote the stop address within %0d cycles", CYCLE_LIMIT);
        end
        if (char_count != 8'd3) begin
            other_errors++;
            $display("expected 3 characters on the output port, saw %0d", char_count);
        end
        if (store_bytes != 4) begin
            other_errors++;
            $display("expected 4 byte writes for the stored word, saw %0d", store_bytes);
        end
        $display("errors: value=%0d other=%0d cycles=%0d", value_errors, other_errors, cycles);
        if (value_errors == 0 && other_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/tb_mem_model.sv
// 128 KB byte RAM with one-cycle read latency, preloaded with the test program
// reads and writes only take effect on edges with rdy high; I/O writes are counted, not stored
`default_nettype none
`include "cpu_config.svh"

module tb_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        rdy,
    input  logic [31:0] addr,
    input  logic        wr,
    input  logic [7:0]  wdata,
    output logic [7:0]  rdata,
    output logic [7:0]  char_count,
    output logic        stop_seen
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] ram [0:`RAM_TOP - 1];

    // little-endian word store for the program image
    task automatic put_word(input logic [16:0] a, input logic [31:0] w);
        ram[a]         = w[7:0];
        ram[a + 17'd1] = w[15:8];
        ram[a + 17'd2] = w[23:16];
        ram[a + 17'd3] = w[31:24];
    endtask

    initial begin
        int i;
        // background mixes every address bit
        for (i = 0; i < `RAM_TOP; i++)
            ram[i[16:0]] = i[7:0] ^ i[15:8] ^ {7'd0, i[16]};
        put_word(17'h00000, 32'h00000513);  // addi a0, x0, 0
        put_word(17'h00004, 32'h00100293);  // addi t0, x0, 1
        put_word(17'h00008, 32'h00b00313);  // addi t1, x0, 11
        put_word(17'h0000c, 32'h00550533);  // loop: add a0, a0, t0
        put_word(17'h00010, 32'h00128293);  // addi t0, t0, 1
        put_word(17'h00014, 32'hfe629ce3);  // bne t0, t1, loop
        put_word(17'h00018, 32'h10a02023);  // sw a0, 0x100(x0)
        put_word(17'h0001c, 32'h10002583);  // lw a1, 0x100(x0)
        put_word(17'h00020, 32'h000303b7);  // lui t2, 0x30
        put_word(17'h00024, 32'h00a59c63);  // bne a1, a0, done
        put_word(17'h00028, 32'h04f00e13);  // addi t3, x0, 'O'
        put_word(17'h0002c, 32'h01c38023);  // sb t3, 0(t2)
        put_word(17'h00030, 32'h04b00e13);  // addi t3, x0, 'K'
        put_word(17'h00034, 32'h01c38023);  // sb t3, 0(t2)
        put_word(17'h00038, 32'h00a38023);  // sb a0, 0(t2)
        put_word(17'h0003c, 32'h00038223);  // done: sb x0, 4(t2)
        put_word(17'h00040, 32'h0000006f);  // jal x0, 0
    end

    always @(posedge clk) begin
        if (rst) begin
            char_count <= 8'd0;
            stop_seen  <= 1'b0;
        end
        if (rdy) begin
            rdata <= ram[addr[16:0]];
            if (wr && addr < `RAM_TOP) begin
                ram[addr[16:0]] = wdata;
            end else if (wr && addr == `IO_OUT_ADDR) begin
                char_count <= char_count + 8'd1;
                $display("io: character 0x%02h", wdata);
            end else if (wr && addr == `IO_STOP_ADDR) begin
                stop_seen <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/cpu.sv
// RV32I multicycle core with a byte-wide memory bus
// all state freezes while rdy_in is low; I/O reads are not supported
`default_nettype none

module cpu
    import cpu_pkg::*;
(
    input  logic        clk_in,
    input  logic        rst,
    input  logic        rdy_in,
    input  logic [7:0]  mem_din,
    output logic [7:0]  mem_dout,
    output logic [31:0] mem_a,
    output logic        mem_wr,
    input  logic        io_buffer_full,
    output logic [31:0] dbgreg_dout
);

    mem_req_t    fetch_req;
    mem_req_t    data_req;
    logic        fetch_done;
    logic [31:0] fetch_word;
    logic        data_done;
    logic [31:0] load_word;
    logic        dec_en;
    logic [31:0] dec_inst;
    logic [31:0] dec_pc;
    logic        issue_en;
    decoded_t    issue;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] wb_val;
    logic        retire_en;
    logic [31:0] next_pc;

    memctrl memctrl (
        .clk_in(clk_in),
        .rst(rst),
        .rdy_in(rdy_in),
        .io_buffer_full(io_buffer_full),
        .fetch_req(fetch_req),
        .data_req(data_req),
        .mem_din(mem_din),
        .mem_dout(mem_dout),
        .mem_a(mem_a),
        .mem_wr(mem_wr),
        .fetch_done(fetch_done),
        .fetch_word(fetch_word),
        .data_done(data_done),
        .load_word(load_word)
    );

    fetcher fetcher (
        .clk_in(clk_in),
        .rst(rst),
        .rdy_in(rdy_in),
        .fetch_req(fetch_req),
        .fetch_done(fetch_done),
        .fetch_word(fetch_word),
        .retire_en(retire_en),
        .next_pc(next_pc),
        .dec_en(dec_en),
        .dec_inst(dec_inst),
        .dec_pc(dec_pc)
    );

    decoder decoder (
        .clk_in(clk_in),
        .rst(rst),
        .rdy_in(rdy_in),
        .dec_en(dec_en),
        .dec_inst(dec_inst),
        .dec_pc(dec_pc),
        .issue_en(issue_en),
        .issue(issue)
    );

    regfile regfile (
        .clk_in(clk_in),
        .rst(rst),
        .rdy_in(rdy_in),
        .rs1(rs1),
        .rs2(rs2),
        .rs1_val(rs1_val),
        .rs2_val(rs2_val),
        .wb_en(wb_en),
        .wb_rd(wb_rd),
        .wb_val(wb_val),
        .dbg_val(dbgreg_dout)
    );

    execute execute (
        .clk_in(clk_in),
        .rst(rst),
        .rdy_in(rdy_in),
        .issue_en(issue_en),
        .issue(issue),
        .rs1(rs1),
        .rs2(rs2),
        .rs1_val(rs1_val),
        .rs2_val(rs2_val),
        .wb_en(wb_en),
        .wb_rd(wb_rd),
        .wb_val(wb_val),
        .data_req(data_req),
        .data_done(data_done),
        .load_word(load_word),
        .retire_en(retire_en),
        .next_pc(next_pc)
    );

endmodule

`default_nettype wire

// File: design/execute.sv
// multicycle execute: READ, ALU, MEM for loads and stores, then WB and retire
// holds one instruction at a time, a new issue is taken only in EX_IDLE
`default_nettype none

module execute
    import cpu_pkg::*;
(
    input  logic        clk_in,
    input  logic        rst,
    input  logic        rdy_in,
    input  logic        issue_en,
    input  decoded_t    issue,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    input  logic [31:0] rs1_val,
    input  logic [31:0] rs2_val,
    output logic        wb_en,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_val,
    output mem_req_t    data_req,
    input  logic        data_done,
    input  logic [31:0] load_word,
    output logic        retire_en,
    output logic [31:0] next_pc
);

    exec_state_e state;
    decoded_t    inst;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_out;
    logic [31:0] result;
    logic [31:0] target;
    logic        taken;
    logic        is_store;
    logic        is_mem;
    logic        writes_rd;
    logic        req_en;

    assign rs1 = inst.rs1;
    assign rs2 = inst.rs2;

    assign is_store  = (inst.op == OP_SW) || (inst.op == OP_SB);
    assign is_mem    = is_store || (inst.op == OP_LW);
    assign writes_rd = !is_store && !(inst.op inside {OP_NOP, OP_BEQ, OP_BNE});

    // result holds the effective address while in EX_MEM
    assign data_req = '{en: req_en, wr: is_store, len: (inst.op == OP_SB) ? 3'd1 : 3'd4,
                        addr: result, data: op_b};

    assign wb_en     = (state == EX_WB) && writes_rd;
    assign wb_rd     = inst.rd;
    assign wb_val    = result;
    assign retire_en = (state == EX_WB);

    always_comb begin
        case (inst.op)
            OP_LUI:  alu_out = inst.imm;
            OP_JAL:  alu_out = inst.pc + 32'd4;
            OP_ADD:  alu_out = op_a + op_b;
            OP_SUB:  alu_out = op_a - op_b;
            OP_AND:  alu_out = op_a & op_b;
            OP_OR:   alu_out = op_a | op_b;
            OP_XOR:  alu_out = op_a ^ op_b;
            OP_SLT:  alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            // ADDI, and the address of loads and stores
            default: alu_out = op_a + inst.imm;
        endcase
    end

    // branch and jump target, otherwise fall through
    assign taken  = (inst.op == OP_JAL)
                 || (inst.op == OP_BEQ && op_a == op_b)
                 || (inst.op == OP_BNE && op_a != op_b);
    assign target = taken ? inst.pc + inst.imm : inst.pc + 32'd4;

    always_ff @(posedge clk_in) begin
        if (rst) begin
            state  <= EX_IDLE;
            req_en <= 1'b0;
        end else if (rdy_in) begin
            req_en <= 1'b0;
            case (state)
                EX_IDLE: begin
                    if (issue_en) begin
                        inst  <= issue;
                        state <= EX_READ;
                    end
                end
                EX_READ: begin
                    op_a  <= rs1_val;
                    op_b  <= rs2_val;
                    state <= EX_ALU;
                end
                EX_ALU: begin
                    result  <= alu_out;
                    next_pc <= target;
                    if (is_mem) begin
                        req_en <= 1'b1;
                        state  <= EX_MEM;
                    end else begin
                        state <= EX_WB;
                    end
                end
                EX_MEM: begin
                    if (data_done) begin
                        if (!is_store)
                            result <= load_word;
                        state <= EX_WB;
                    end
                end
                default: state <= EX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/regfile.sv
// 32 x 32 integer register file, two combinational reads and one write
// x0 is never written, so it reads as zero from reset on
`default_nettype none
`include "cpu_config.svh"

module regfile (
    input  logic        clk_in,
    input  logic        rst,
    input  logic        rdy_in,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    output logic [31:0] rs1_val,
    output logic [31:0] rs2_val,
    input  logic        wb_en,
    input  logic [4:0]  wb_rd,
    input  logic [31:0] wb_val,
    output logic [31:0] dbg_val
);

    logic [31:0] regs [32];

    assign rs1_val = regs[rs1];
    assign rs2_val = regs[rs2];

    // a0 mirrored for the debug port
    assign dbg_val = regs[`DBG_REG];

    always_ff @(posedge clk_in) begin
        if (rst) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= 32'd0;
        end else if (rdy_in && wb_en && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_val;
        end
    end

endmodule

`default_nettype wire

// File: design/decoder.sv
// RV32I decode stage, one register between fetch and execute
// encodings outside the supported subset decode to OP_NOP
`default_nettype none

module decoder
    import cpu_pkg::*;
(
    input  logic        clk_in,
    input  logic        rst,
    input  logic        rdy_in,
    input  logic        dec_en,
    input  logic [31:0] dec_inst,
    input  logic [31:0] dec_pc,
    output logic        issue_en,
    output decoded_t    issue
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    decoded_t   dec;

    assign opcode = dec_inst[6:0];
    assign funct3 = dec_inst[14:12];
    assign funct7 = dec_inst[31:25];

    always_comb begin
        dec.op  = OP_NOP;
        dec.rd  = dec_inst[11:7];
        dec.rs1 = dec_inst[19:15];
        dec.rs2 = dec_inst[24:20];
        dec.pc  = dec_pc;
        // I-type immediate unless the format says otherwise
        dec.imm = {{20{dec_inst[31]}}, dec_inst[31:20]};
        case (opcode)
            7'b0110111: begin
                dec.op  = OP_LUI;
                dec.imm = {dec_inst[31:12], 12'd0};
            end
            7'b1101111: begin
                dec.op  = OP_JAL;
                dec.imm = {{12{dec_inst[31]}}, dec_inst[19:12], dec_inst[20],
                           dec_inst[30:21], 1'b0};
            end
            7'b1100011: begin
                dec.imm = {{20{dec_inst[31]}}, dec_inst[7], dec_inst[30:25],
                           dec_inst[11:8], 1'b0};
                if (funct3 == 3'b000)
                    dec.op = OP_BEQ;
                else if (funct3 == 3'b001)
                    dec.op = OP_BNE;
            end
            7'b0010011: begin
                if (funct3 == 3'b000)
                    dec.op = OP_ADDI;
            end
            7'b0000011: begin
                if (funct3 == 3'b010)
                    dec.op = OP_LW;
            end
            7'b0100011: begin
                dec.imm = {{20{dec_inst[31]}}, dec_inst[31:25], dec_inst[11:7]};
                if (funct3 == 3'b010)
                    dec.op = OP_SW;
                else if (funct3 == 3'b000)
                    dec.op = OP_SB;
            end
            7'b0110011: begin
                case ({funct7, funct3})
                    10'b0000000_000: dec.op = OP_ADD;
                    10'b0100000_000: dec.op = OP_SUB;
                    10'b0000000_111: dec.op = OP_AND;
                    10'b0000000_110: dec.op = OP_OR;
                    10'b0000000_100: dec.op = OP_XOR;
                    10'b0000000_010: dec.op = OP_SLT;
                    default:         dec.op = OP_NOP;
                endcase
            end
            default: dec.op = OP_NOP;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst) begin
            issue_en <= 1'b0;
        end else if (rdy_in) begin
            issue_en <= dec_en;
            if (dec_en)
                issue <= dec;
        end
    end

endmodule

`default_nettype wire

// File: design/fetcher.sv
// instruction fetch for the single-issue core
// the next fetch starts only after the previous instruction retires
`default_nettype none
`include "cpu_config.svh"

module fetcher
    import cpu_pkg::*;
(
    input  logic        clk_in,
    input  logic        rst,
    input  logic        rdy_in,
    output mem_req_t    fetch_req,
    input  logic        fetch_done,
    input  logic [31:0] fetch_word,
    input  logic        retire_en,
    input  logic [31:0] next_pc,
    output logic        dec_en,
    output logic [31:0] dec_inst,
    output logic [31:0] dec_pc
);

    logic [31:0] pc;
    logic        need_fetch;

    // one-cycle word request, memctrl is idle whenever it is raised
    assign fetch_req = '{en: need_fetch, wr: 1'b0, len: 3'd4, addr: pc, data: 32'd0};

    always_ff @(posedge clk_in) begin
        if (rst) begin
            pc         <= `RESET_PC;
            need_fetch <= 1'b1;
            dec_en     <= 1'b0;
        end else if (rdy_in) begin
            dec_en     <= fetch_done;
            need_fetch <= 1'b0;
            if (fetch_done) begin
                dec_inst <= fetch_word;
                dec_pc   <= pc;
            end
            // retired instruction hands back the pc to fetch next
            if (retire_en) begin
                pc         <= next_pc;
                need_fetch <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/memctrl.sv
// byte sequencer between the core and the 8-bit memory bus, little-endian
// bus outputs follow registered state, except mem_wr to the output port
`default_nettype none
`include "cpu_config.svh"

module memctrl
    import cpu_pkg::*;
(
    input  logic        clk_in,
    input  logic        rst,
    input  logic        rdy_in,
    input  logic        io_buffer_full,
    input  mem_req_t    fetch_req,
    input  mem_req_t    data_req,
    input  logic [7:0]  mem_din,
    output logic [7:0]  mem_dout,
    output logic [31:0] mem_a,
    output logic        mem_wr,
    output logic        fetch_done,
    output logic [31:0] fetch_word,
    output logic        data_done,
    output logic [31:0] load_word
);

    mc_state_e   state;
    mem_req_t    req;
    logic [2:0]  cnt;
    logic [31:0] word;
    logic        io_hold;

    // UART full only stalls writes to the character port
    assign io_hold = req.wr && (req.addr == `IO_OUT_ADDR) && io_buffer_full;

    // byte cnt of the latched request is on the bus
    assign mem_a    = (state == MC_IDLE) ? 32'd0 : req.addr + {29'd0, cnt};
    assign mem_wr   = (state == MC_DATA) && req.wr && !io_hold;
    assign mem_dout = (state == MC_DATA && req.wr) ? req.data[8 * cnt[1:0] +: 8] : 8'd0;

    assign fetch_word = word;
    assign load_word  = word;

    always_ff @(posedge clk_in) begin
        if (rst) begin
            state      <= MC_IDLE;
            cnt        <= 3'd0;
            fetch_done <= 1'b0;
            data_done  <= 1'b0;
        end else if (rdy_in) begin
            fetch_done <= 1'b0;
            data_done  <= 1'b0;
            case (state)
                MC_IDLE: begin
                    cnt <= 3'd0;
                    // fetch first, the two never collide in practice
                    if (fetch_req.en) begin
                        req   <= fetch_req;
                        state <= MC_FETCH;
                    end else if (data_req.en) begin
                        req   <= data_req;
                        state <= MC_DATA;
                    end
                end
                default: begin
                    if (!req.wr) begin
                        // data for byte cnt-1 arrives one cycle behind its address
                        if (cnt != 3'd0)
                            word[{cnt[1:0] - 2'd1, 3'b000} +: 8] <= mem_din;
                        if (cnt == req.len) begin
                            state      <= MC_IDLE;
                            fetch_done <= (state == MC_FETCH);
                            data_done  <= (state == MC_DATA);
                        end else begin
                            cnt <= cnt + 3'd1;
                        end
                    end else if (!io_hold) begin
                        if (cnt == req.len - 3'd1) begin
                            state     <= MC_IDLE;
                            data_done <= 1'b1;
                        end else begin
                            cnt <= cnt + 3'd1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/cpu_pkg.sv
// shared types for the multicycle RV32I core
// only the operations in opcode_e are executed, anything else runs as OP_NOP
`default_nettype none

package cpu_pkg;

    // supported operations
    typedef enum logic [3:0] {
        OP_NOP,
        OP_LUI,
        OP_JAL,
        OP_BEQ,
        OP_BNE,
        OP_ADDI,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_LW,
        OP_SW,
        OP_SB
    } opcode_e;

    typedef enum logic [2:0] {
        EX_IDLE,
        EX_READ,
        EX_ALU,
        EX_MEM,
        EX_WB
    } exec_state_e;

    typedef enum logic [1:0] {
        MC_IDLE,
        MC_FETCH,
        MC_DATA
    } mc_state_e;

    // one access on the byte bus, len counts bytes (1 or 4)
    typedef struct packed {
        logic        en;
        logic        wr;
        logic [2:0]  len;
        logic [31:0] addr;
        logic [31:0] data;
    } mem_req_t;

    typedef struct packed {
        opcode_e     op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        logic [31:0] pc;
    } decoded_t;

endpackage

`default_nettype wire

// File: design/cpu_config.svh
// memory map and start values for the RV32I core
// RAM is 128 KB from address zero, I/O sits where address bits 17:16 are set
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// first byte above RAM
`define RAM_TOP      32'h0002_0000

// output character port and program stop port
`define IO_OUT_ADDR  32'h0003_0000
`define IO_STOP_ADDR 32'h0003_0004

// fetch start and the register shown on the debug port (a0)
`define RESET_PC     32'h0000_0000
`define DBG_REG      5'd10

`endif
